// File: filelist.f
zports_pkg.sv
io_cycle_decode.sv
port_regs.sv
port_readback.sv
zports_top.sv
tb_clkgen.sv
tb_zports.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_zports
FILELIST  = filelist.f
OBJDIR    = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJDIR)

// File: tb_zports.sv
////////////////////////////////////////
// directed tests of the port block against a small reference model
// io cycles are held 3 clocks then idle 2, inputs move 1 ns after the edge
////////////////////////////////////////

module tb_zports import zports_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD      = 4;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 200;

	logic       zclk;
	logic       rst_n;
	io_bus_t    bus;
	logic       dos;
	logic       rstrom;
	logic [4:0] keys_in;
	logic       tape_read;
	logic [4:0] kj_in;
	logic [7:0] mus_in;
	logic [7:0] dout;
	logic       dataout;
	logic       porthit;
	vid_cfg_t   vid;
	mem_cfg_t   mem;
	sys_cfg_t   sys;

	// reference model state
	vid_cfg_t   exp_vid;
	mem_cfg_t   exp_mem;
	sys_cfg_t   exp_sys;
	logic       exp_lock;

	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          test_errors0;

	// result of the last io_read
	logic [7:0] rd_data;
	logic       rd_hit;
	logic       rd_en;

	tb_clkgen u_clkgen (
		.zclk  (zclk),
		.rst_n (rst_n)
	);

	zports_top uut (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.bus       (bus),
		.dos       (dos),
		.rstrom    (rstrom),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.dout      (dout),
		.dataout   (dataout),
		.porthit   (porthit),
		.vid       (vid),
		.mem       (mem),
		.sys       (sys)
	);

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24]; // top bits have the longest period
	endfunction

	////////////////////////////////////////
	// bus cycles
	task automatic step();
		@(posedge zclk);
		#1;
	endtask

	task automatic bus_idle();
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		bus.addr   = a;
		bus.din    = d;
		bus.iorq_n = 1'b0;
		bus.wr_n   = 1'b0;
		repeat (3) step();
		bus_idle();
		repeat (2) step();
	endtask

	task automatic io_read(input logic [15:0] a);
		bus.addr   = a;
		bus.iorq_n = 1'b0;
		bus.rd_n   = 1'b0;
		repeat (3) step();
		rd_data = dout; // address has gone through both bus registers
		rd_hit  = porthit;
		rd_en   = dataout;
		bus_idle();
		repeat (2) step();
	endtask

	////////////////////////////////////////
	// compare tasks
	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_vid(input string name, input vid_cfg_t got, input vid_cfg_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_mem(input string name, input mem_cfg_t got, input mem_cfg_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_all();
		check_vid("vid", vid, exp_vid);
		check_mem("mem", mem, exp_mem);
		check_byte("p7ffd", sys.p7ffd, exp_sys.p7ffd);
		check_byte("peff7", sys.peff7, exp_sys.peff7);
		check_byte("bf", {6'b0, sys.romrw_en, sys.shadow_en},
			{6'b0, exp_sys.romrw_en, exp_sys.shadow_en});
	endtask

	task automatic read_and_check(input string name, input logic [15:0] a,
		input logic [7:0] exp_data, input logic exp_hit);
		io_read(a);
		check_byte(name, rd_data, exp_data);
		check_byte("porthit", {7'b0, rd_hit}, {7'b0, exp_hit});
		check_byte("dataout", {7'b0, rd_en}, {7'b0, exp_hit}); // read is active
	endtask

	task automatic start_test();
		test_errors0 = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_errors0)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_errors0);
		end
	endtask

	////////////////////////////////////////
	// writes with model update
	task automatic init_model();
		exp_vid          = '0;
		exp_vid.vpage    = RST_VPAGE;
		exp_vid.hint_beg = RST_HINT;
		exp_vid.im2vect  = RST_IM2VECT;
		exp_mem              = '0;
		exp_mem.rampage      = RST_RAMPAGE;
		exp_mem.pent1m_rom   = rstrom;
		exp_mem.pent1m_1m_on = 1'b1; // EFF7 clear
		exp_sys  = '0;
		exp_lock = 1'b0;
	endtask

	task automatic write_xt(input logic [7:0] idx, input logic [7:0] d);
		logic [1:0] page;
		io_write({idx, PORT_XT}, d);
		page = 2'(idx - XT_RAMPAGE);
		case (idx)
			XT_VCONF:   exp_vid.vconf         = d;
			XT_VPAGE:   exp_vid.vpage         = d;
			XT_XOFFS_L: exp_vid.x_offs[7:0]   = d;
			XT_XOFFS_H: exp_vid.x_offs[8]     = d[0];
			XT_YOFFS_L: exp_vid.y_offs[7:0]   = d;
			XT_YOFFS_H: exp_vid.y_offs[8]     = d[0];
			XT_TSCONF:  exp_vid.tsconf        = d;
			XT_BORDER:  exp_vid.border        = d;
			XT_ROMPAGE: exp_mem.rompage       = d[4:0];
			XT_SYSCONF: exp_mem.sysconf       = d;
			XT_MEMCONF: exp_mem.memconf       = d;
			XT_HSINT:   exp_vid.hint_beg      = d;
			XT_VSINT_L: exp_vid.vint_beg[7:0] = d;
			XT_VSINT_H: exp_vid.vint_beg[8]   = d[0];
			XT_IM2VECT: exp_vid.im2vect       = d;
			default:
			begin
				if (idx >= XT_RAMPAGE && idx < XT_RAMPAGE + 8'd4)
				begin
					exp_mem.rampage[page]     = d;
					exp_mem.xt_override[page] = 1'b1;
				end
			end
		endcase
	endtask

	task automatic write_7ffd(input logic [7:0] d);
		io_write(16'h7FFD, d);
		if (!exp_lock)
		begin
			exp_sys.p7ffd  = d;
			exp_vid.vpage  = d[3] ? 8'h07 : 8'h05;
			if (exp_sys.peff7[2])
				exp_mem.pent1m_page = {3'b000, d[2:0]}; // 128k only
			else
				exp_mem.pent1m_page = {d[5], d[7:6], d[2:0]};
			exp_mem.pent1m_rom     = d[4];
			exp_mem.xt_override[3] = 1'b0;
			exp_lock               = d[5] & exp_sys.peff7[2];
		end
	endtask

	task automatic write_eff7(input logic [7:0] d);
		io_write(16'hEFF7, d);
		if (!(dos || exp_sys.shadow_en))
		begin
			exp_sys.peff7         = d;
			exp_mem.pent1m_1m_on  = ~d[2];
			exp_mem.pent1m_ram0_0 = d[3];
		end
	endtask

	task automatic write_bf(input logic [7:0] d);
		io_write({8'h00, PORT_BF}, d);
		exp_sys.shadow_en = d[0];
		exp_sys.romrw_en  = d[1];
	endtask

	////////////////////////////////////////
	// tests
	task automatic test_reset_defaults();
		vid_cfg_t v;
		mem_cfg_t m;
		start_test();
		v         = vid;
		m         = mem;
		v.border  = '0; // border and rompage come up unknown
		m.rompage = '0;
		check_vid("vid", v, exp_vid);
		check_mem("mem", m, exp_mem);
		check_byte("p7ffd", sys.p7ffd, 8'h00);
		check_byte("peff7", sys.peff7, 8'h00);
		finish_test("reset_defaults");
	endtask

	task automatic test_ext_writes();
		logic [7:0] idx_list [17];
		start_test();
		idx_list = '{XT_VCONF, XT_VPAGE, XT_XOFFS_L, XT_XOFFS_H, XT_YOFFS_L,
			XT_YOFFS_H, XT_TSCONF, XT_RAMPAGE, XT_RAMPAGE + 8'd1, XT_RAMPAGE + 8'd2,
			XT_RAMPAGE + 8'd3, XT_SYSCONF, XT_MEMCONF, XT_HSINT, XT_VSINT_L,
			XT_VSINT_H, XT_IM2VECT};
		write_xt(XT_BORDER, rand_byte()); // the two unreset ones first
		write_xt(XT_ROMPAGE, rand_byte());
		for (int i = 0; i < 17; i++)
		begin
			write_xt(idx_list[i], rand_byte());
			check_vid("vid", vid, exp_vid);
			check_mem("mem", mem, exp_mem);
		end
		finish_test("ext_writes");
	endtask

	task automatic test_border();
		logic [7:0] d;
		start_test();
		d = rand_byte();
		io_write({8'h00, PORT_FE}, d);
		exp_vid.border = 8'hF0 + {5'b00000, d[2:0]};
		check_byte("border", vid.border, exp_vid.border);
		write_xt(XT_BORDER, rand_byte());
		check_byte("border", vid.border, exp_vid.border);
		check_vid("vid", vid, exp_vid);
		finish_test("border");
	endtask

	task automatic test_7ffd_paging();
		logic [7:0] d;
		start_test();
		d = rand_byte() & 8'hD7; // screen 5, no lock bit
		write_7ffd(d);
		check_all();
		write_7ffd(rand_byte() | 8'h08); // screen 7
		check_all();
		write_eff7(rand_byte() | 8'h04); // back to 128k paging
		check_all();
		d = rand_byte() | 8'h20;
		write_7ffd(d);
		check_all();
		write_7ffd(~d);
		check_all();
		finish_test("7ffd_paging");
	endtask

	task automatic test_eff7_shadow();
		start_test();
		write_eff7(rand_byte());
		check_all();
		write_bf(8'h01);
		check_all();
		read_and_check("dout f7", 16'hEFF7, 8'hFF, 1'b0);
		write_eff7(~exp_sys.peff7); // lost in shadow mode
		check_all();
		read_and_check("dout be", {4'h0, BE_SEL_7FFD, PORT_BE}, exp_sys.p7ffd, 1'b1);
		read_and_check("dout be", {4'h0, BE_SEL_EFF7, PORT_BE}, exp_sys.peff7, 1'b1);
		read_and_check("dout bf", {8'h00, PORT_BF}, 8'h01, 1'b1);
		write_bf(8'h02);
		read_and_check("dout bf", {8'h00, PORT_BF}, 8'h02, 1'b1);
		check_all();
		finish_test("eff7_shadow");
	endtask

	task automatic test_reads();
		logic [7:0] r;
		start_test();
		r         = rand_byte();
		keys_in   = r[4:0];
		tape_read = r[7];
		read_and_check("dout fe", 16'h00FE, {1'b1, r[7], 1'b0, r[4:0]}, 1'b1);
		r     = rand_byte();
		kj_in = r[4:0];
		read_and_check("dout 1f", 16'h001F, {3'b000, r[4:0]}, 1'b1);
		r      = rand_byte();
		mus_in = r;
		read_and_check("dout df", 16'h00DF, r, 1'b1);
		read_and_check("dout 55", 16'h0055, 8'hFF, 1'b0);
		finish_test("reads");
	endtask

	////////////////////////////////////////
	initial
	begin
		bus.addr     = '0;
		bus.din      = '0;
		bus_idle();
		dos          = 1'b0;
		rstrom       = 1'b1;
		keys_in      = '0;
		tape_read    = 1'b0;
		kj_in        = '0;
		mus_in       = '0;
		lcg_state    = 32'h8c4813bf;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errors0 = 0;
		init_model();
		wait (rst_n === 1'b1);
		step();
		test_reset_defaults();
		test_ext_writes();
		test_border();
		test_7ffd_paging();
		test_eff7_shadow();
		test_reads();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog: run did not end within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tb_clkgen.sv
////////////////////////////////////////
// 4 ns zclk, rst_n low for the first 8 edges
////////////////////////////////////////

module tb_clkgen
(
	output logic zclk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 2;
	localparam int RST_CYCLES  = 8;

	initial
	begin
		zclk = 1'b0;
		forever #HALF_PERIOD zclk = ~zclk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge zclk);
		#1 rst_n = 1'b1; // released off the edge like the other inputs
	end

endmodule

// File: zports_top.sv
////////////////////////////////////////
// single zclk domain, writes land two edges after the sample
////////////////////////////////////////

module zports_top import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  io_bus_t    bus,
	input  logic       dos,
	input  logic       rstrom,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [4:0] kj_in,
	input  logic [7:0] mus_in,
	output logic [7:0] dout,
	output logic       dataout,
	output logic       porthit,
	output vid_cfg_t   vid,
	output mem_cfg_t   mem,
	output sys_cfg_t   sys
);

	port_sel_t  sel;
	z80_addr_u  addr;
	logic [7:0] data;
	logic       shadow;

	io_cycle_decode u_decode (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.bus    (bus),
		.shadow (shadow),
		.sel    (sel),
		.addr   (addr),
		.data   (data)
	);

	port_regs u_regs (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.sel    (sel),
		.addr   (addr),
		.data   (data),
		.dos    (dos),
		.rstrom (rstrom),
		.shadow (shadow),
		.vid    (vid),
		.mem    (mem),
		.sys    (sys)
	);

	port_readback u_readback (
		.addr      (addr),
		.bus_rd    (~(bus.iorq_n | bus.rd_n)), // raw in cycle
		.shadow    (shadow),
		.sys       (sys),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.dout      (dout),
		.porthit   (porthit),
		.dataout   (dataout)
	);

endmodule

// File: port_readback.sv
////////////////////////////////////////
// purely combinational, follows the registered address
////////////////////////////////////////

module port_readback import zports_pkg::*;
(
	input  z80_addr_u  addr,
	input  logic       bus_rd,
	input  logic       shadow,
	input  sys_cfg_t   sys,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [4:0] kj_in,
	input  logic [7:0] mus_in,
	output logic [7:0] dout,
	output logic       porthit,
	output logic       dataout
);

	logic [7:0] lo;
	logic [3:0] be_sel;
	logic [7:0] be_data;

	assign lo     = addr.std.lo;
	assign be_sel = {addr.std.a11_9, addr.std.a8};

	// #BE config readback
	always_comb
	begin
		case (be_sel)
			BE_SEL_7FFD: be_data = sys.p7ffd;
			BE_SEL_EFF7: be_data = sys.peff7;
			default:     be_data = 8'hFF;
		endcase
	end

	////////////////////////////////////////
	// read data mux
	always_comb
	begin
		case (lo)
			PORT_FE:     dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_KJOY:   dout = shadow ? 8'hFF : {3'b000, kj_in}; // 1F is fdc in shadow
			PORT_KMOUSE: dout = mus_in;
			PORT_BF:     dout = {6'b000000, sys.romrw_en, sys.shadow_en};
			PORT_BE:     dout = be_data;
			default:     dout = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (lo)
			PORT_FE, PORT_FD, PORT_XT, PORT_KMOUSE, PORT_BF, PORT_BE:
				porthit = 1'b1;
			PORT_KJOY, PORT_F7:
				porthit = ~shadow; // owned by shadow ports otherwise
			default:
				porthit = 1'b0;
		endcase
	end

	assign dataout = porthit & bus_rd;

endmodule

// File: port_regs.sv
////////////////////////////////////////
// registers update one zclk after the write strobe
// border and rompage come up undefined, 7FFD lock clears only on reset
////////////////////////////////////////

module port_regs import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  port_sel_t  sel,
	input  z80_addr_u  addr,
	input  logic [7:0] data,
	input  logic       dos,
	input  logic       rstrom,
	output logic       shadow,
	output vid_cfg_t   vid,
	output mem_cfg_t   mem,
	output sys_cfg_t   sys
);

	logic [7:0]      vconf;
	logic [7:0]      vpage;
	logic [8:0]      x_offs;
	logic [8:0]      y_offs;
	logic [7:0]      tsconf;
	logic [7:0]      border;
	logic [7:0]      hint_beg;
	logic [8:0]      vint_beg;
	logic [7:0]      im2vect;
	logic [3:0][7:0] rampage;
	logic [4:0]      rompage;
	logic [3:0]      xt_override;
	logic [7:0]      sysconf;
	logic [7:0]      memconf;
	logic [5:0]      pent1m_page;
	logic            pent1m_rom;
	logic [7:0]      p7ffd;
	logic [7:0]      peff7;
	logic            lock;      // 7FFD write lock
	logic            shadow_en;
	logic            romrw_en;

	logic [7:0]      idx;
	logic            xt_wr;
	logic            rampage_hit;
	logic            p7ffd_wr;
	logic            peff7_wr;
	logic            block1m;   // EFF7 bit 2, back to 128k paging

	assign idx         = addr.xt.idx;
	assign xt_wr       = sel.xt & sel.wr_stb;
	assign rampage_hit = (idx[7:2] == XT_RAMPAGE[7:2]);
	assign p7ffd_wr    = sel.fd & sel.wr_stb & ~addr.std.a15 & ~lock;
	assign peff7_wr    = sel.f7 & sel.wr_stb & ~addr.std.a12 & ~shadow;
	assign block1m     = peff7[2];
	assign shadow      = dos | shadow_en;

	////////////////////////////////////////
	// ext register file
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			vconf    <= '0;
			x_offs   <= '0;
			y_offs   <= '0;
			tsconf   <= '0;
			hint_beg <= RST_HINT;
			vint_beg <= '0;
			im2vect  <= RST_IM2VECT;
			sysconf  <= '0;
			memconf  <= '0;
			rampage  <= RST_RAMPAGE;
		end
		else if (xt_wr)
		begin
			case (idx)
				XT_VCONF:   vconf          <= data;
				XT_XOFFS_L: x_offs[7:0]    <= data;
				XT_XOFFS_H: x_offs[8]      <= data[0];
				XT_YOFFS_L: y_offs[7:0]    <= data;
				XT_YOFFS_H: y_offs[8]      <= data[0];
				XT_TSCONF:  tsconf         <= data;
				XT_SYSCONF: sysconf        <= data;
				XT_MEMCONF: memconf        <= data;
				XT_HSINT:   hint_beg       <= data;
				XT_VSINT_L: vint_beg[7:0]  <= data;
				XT_VSINT_H: vint_beg[8]    <= data[0];
				XT_IM2VECT: im2vect        <= data;
				default:    ;
			endcase
			if (rampage_hit)
				rampage[idx[1:0]] <= data;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (xt_wr && idx == XT_ROMPAGE)
			rompage <= data[4:0];
	end

	// rampage write takes the window over, 7FFD gives the top one back
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			xt_override <= '0;
		else
		begin
			if (xt_wr && rampage_hit)
				xt_override[idx[1:0]] <= 1'b1;
			if (p7ffd_wr)
				xt_override[3] <= 1'b0;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (sel.fe && sel.wr_stb)
			border <= {5'b11110, data[2:0]}; // zx colours in the top of the palette
		else if (xt_wr && idx == XT_BORDER)
			border <= data;
	end

	////////////////////////////////////////
	// 7FFD paging
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd       <= '0;
			lock        <= 1'b0;
			vpage       <= RST_VPAGE;
			pent1m_page <= '0;
		end
		else if (p7ffd_wr)
		begin
			p7ffd       <= data;
			vpage       <= {6'b000001, data[3], 1'b1}; // screen 5 or 7
			pent1m_page <= {block1m ? 3'b000 : {data[5], data[7:6]}, data[2:0]};
			lock        <= data[5] & block1m; // 128k lock bit
		end
		else if (xt_wr && idx == XT_VPAGE)
			vpage <= data;
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			pent1m_rom <= rstrom; // boot rom choice
		else if (p7ffd_wr)
			pent1m_rom <= data[4];
	end

	// EFF7 and BF
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			peff7     <= '0;
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
		end
		else
		begin
			if (peff7_wr)
				peff7 <= data;
			if (sel.bf && sel.wr_stb)
			begin
				shadow_en <= data[0];
				romrw_en  <= data[1];
			end
		end
	end

	always_comb
	begin
		vid.vconf         = vconf;
		vid.vpage         = vpage;
		vid.x_offs        = x_offs;
		vid.y_offs        = y_offs;
		vid.tsconf        = tsconf;
		vid.border        = border;
		vid.hint_beg      = hint_beg;
		vid.vint_beg      = vint_beg;
		vid.im2vect       = im2vect;
		mem.rampage       = rampage;
		mem.rompage       = rompage;
		mem.xt_override   = xt_override;
		mem.sysconf       = sysconf;
		mem.memconf       = memconf;
		mem.pent1m_page   = pent1m_page;
		mem.pent1m_rom    = pent1m_rom;
		mem.pent1m_1m_on  = ~block1m;
		mem.pent1m_ram0_0 = peff7[3];
		sys.shadow_en     = shadow_en;
		sys.romrw_en      = romrw_en;
		sys.p7ffd         = p7ffd;
		sys.peff7         = peff7;
	end

	// once locked, 7FFD stays frozen until reset
	a_lock_sticky: assert property (@(posedge zclk) lock && rst_n |=> lock);

endmodule

// File: io_cycle_decode.sv
////////////////////////////////////////
// bus is sampled once per zclk, strobe one cycle after the sample
// a held cycle gives a single strobe, the bus must go idle in between
////////////////////////////////////////

module io_cycle_decode import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  io_bus_t    bus,
	input  logic       shadow,
	output port_sel_t  sel,
	output z80_addr_u  addr,
	output logic [7:0] data
);

	io_bus_t    bus_q;  // raw bus sample
	logic       iowr;
	logic       iord;
	logic       iowr_d; // level seen on the previous sample
	logic       iord_d;
	logic       wr_stb;
	logic       rd_stb;
	logic [7:0] lo;

	always_ff @(posedge zclk)
	begin
		bus_q <= bus;
	end

	assign iowr = ~(bus_q.iorq_n | bus_q.wr_n);
	assign iord = ~(bus_q.iorq_n | bus_q.rd_n);

	////////////////////////////////////////
	// edge detect on the sampled levels
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_d <= 1'b0;
			iord_d <= 1'b0;
			wr_stb <= 1'b0;
			rd_stb <= 1'b0;
		end
		else
		begin
			iowr_d <= iowr;
			iord_d <= iord;
			wr_stb <= iowr & ~iowr_d; // first sample of the cycle only
			rd_stb <= iord & ~iord_d;
		end
	end

	// address and data kept in step with the strobes
	always_ff @(posedge zclk)
	begin
		addr <= bus_q.addr;
		data <= bus_q.din;
	end

	////////////////////////////////////////
	// port decode
	assign lo = addr.std.lo;

	always_comb
	begin
		sel.fe     = (lo == PORT_FE);
		sel.fd     = (lo == PORT_FD);
		sel.xt     = (lo == PORT_XT);
		// xEF7 style in shadow mode, keeps clear of the shadow xFF7 ports
		sel.f7     = (lo == PORT_F7) && (addr.std.a8 != shadow);
		sel.bf     = (lo == PORT_BF);
		sel.wr_stb = wr_stb;
		sel.rd_stb = rd_stb;
	end

	// a z80 cycle is either in or out, never both
	a_stb_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(wr_stb && rd_stb));

endmodule

// File: zports_pkg.sv
////////////////////////////////////////
// port map, ext register indices and reset values of the zclk port block
// ports decode on the low address byte, ext registers on the high byte
////////////////////////////////////////

package zports_pkg;

	// port low bytes
	localparam logic [7:0] PORT_FE     = 8'hFE; // border out, keys and tape in
	localparam logic [7:0] PORT_FD     = 8'hFD; // 7FFD paging when a15 clear
	localparam logic [7:0] PORT_XT     = 8'hAF; // ext register file
	localparam logic [7:0] PORT_F7     = 8'hF7; // EFF7
	localparam logic [7:0] PORT_KJOY   = 8'h1F; // kempston joystick
	localparam logic [7:0] PORT_KMOUSE = 8'hDF; // kempston mouse
	localparam logic [7:0] PORT_BF     = 8'hBF; // config port
	localparam logic [7:0] PORT_BE     = 8'hBE; // config readback

	// ext register indices on #nnAF
	localparam logic [7:0] XT_VCONF    = 8'h00;
	localparam logic [7:0] XT_VPAGE    = 8'h01;
	localparam logic [7:0] XT_XOFFS_L  = 8'h02;
	localparam logic [7:0] XT_XOFFS_H  = 8'h03; // bit 0 only
	localparam logic [7:0] XT_YOFFS_L  = 8'h04;
	localparam logic [7:0] XT_YOFFS_H  = 8'h05; // bit 0 only
	localparam logic [7:0] XT_TSCONF   = 8'h06;
	localparam logic [7:0] XT_BORDER   = 8'h0F;
	localparam logic [7:0] XT_RAMPAGE  = 8'h10; // #10..#13
	localparam logic [7:0] XT_ROMPAGE  = 8'h14;
	localparam logic [7:0] XT_SYSCONF  = 8'h20;
	localparam logic [7:0] XT_MEMCONF  = 8'h21;
	localparam logic [7:0] XT_HSINT    = 8'h22;
	localparam logic [7:0] XT_VSINT_L  = 8'h23;
	localparam logic [7:0] XT_VSINT_H  = 8'h24; // bit 0 only
	localparam logic [7:0] XT_IM2VECT  = 8'h25;

	// #BE readback selectors, address bits 11..8
	localparam logic [3:0] BE_SEL_7FFD = 4'hA;
	localparam logic [3:0] BE_SEL_EFF7 = 4'hB;

	// reset values
	localparam logic [7:0] RST_VPAGE   = 8'h05;
	localparam logic [7:0] RST_HINT    = 8'd2; // pentagon int position
	localparam logic [7:0] RST_IM2VECT = 8'hFF;
	// rampage[0] is the rightmost byte
	localparam logic [3:0][7:0] RST_RAMPAGE = {8'h00, 8'h02, 8'h05, 8'h00};

	// ext view of the z80 address
	typedef struct packed {
		logic [7:0] idx;  // register index
		logic [7:0] port;
	} xt_addr_t;

	// standard view, single select bits
	typedef struct packed {
		logic       a15;
		logic       a14;
		logic       a13;
		logic       a12;
		logic [2:0] a11_9;
		logic       a8;
		logic [7:0] lo;
	} std_addr_t;

	typedef union packed {
		xt_addr_t  xt;
		std_addr_t std;
	} z80_addr_u;

	typedef struct packed {
		z80_addr_u  addr;
		logic [7:0] din;
		logic       iorq_n;
		logic       rd_n;
		logic       wr_n;
	} io_bus_t;

	typedef struct packed {
		logic fe;
		logic fd;
		logic xt;
		logic f7;     // already qualified by a8 and shadow
		logic bf;
		logic wr_stb; // one zclk per io write cycle
		logic rd_stb; // one zclk per io read cycle
	} port_sel_t;

	typedef struct packed {
		logic [7:0] vconf;
		logic [7:0] vpage;
		logic [8:0] x_offs;
		logic [8:0] y_offs;
		logic [7:0] tsconf;
		logic [7:0] border;
		logic [7:0] hint_beg;
		logic [8:0] vint_beg;
		logic [7:0] im2vect;
	} vid_cfg_t;

	typedef struct packed {
		logic [3:0][7:0] rampage;
		logic [4:0]      rompage;
		logic [3:0]      xt_override;
		logic [7:0]      sysconf;
		logic [7:0]      memconf;
		logic [5:0]      pent1m_page;
		logic            pent1m_rom;
		logic            pent1m_1m_on;
		logic            pent1m_ram0_0;
	} mem_cfg_t;

	typedef struct packed {
		logic       shadow_en;
		logic       romrw_en;
		logic [7:0] p7ffd;
		logic [7:0] peff7;
	} sys_cfg_t;

endpackage
